// ==== memStage_config.svh ====
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

//////////////////////////////
// Address map
//////////////////////////////

// Data RAM starts at zero
`define MEM_DM_LAST    32'h0000_2fff

// Timer windows of three words each
`define MEM_TC0_FIRST  32'h0000_7f00
`define MEM_TC0_LAST   32'h0000_7f0b
`define MEM_TC1_FIRST  32'h0000_7f10
`define MEM_TC1_LAST   32'h0000_7f1b

// Interrupt word
`define MEM_IRQ_FIRST  32'h0000_7f20
`define MEM_IRQ_LAST   32'h0000_7f23

// Count words are read only
`define MEM_TC0_COUNT  32'h0000_7f08
`define MEM_TC1_COUNT  32'h0000_7f18

//////////////////////////////
// Storage sizes
//////////////////////////////

`define MEM_DM_WORDS   3072
`define MEM_DEV_WORDS  7

`endif

// ==== memPkg.sv ====
package memPkg;

    // Access size in the memory op coding of the pipeline
    typedef enum logic [1:0] {
        sizeWord = 2'b00,
        sizeHalf = 2'b01,
        sizeByte = 2'b10
    } accSize_e;

    // One bus word seen as bytes, halves or whole
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
        logic [31:0]      word;
    } memWord_u;

    //////////////////////////////
    // Pipeline side
    //////////////////////////////

    typedef struct packed {
        logic [31:0] addr;
        accSize_e    size;
        logic        isStore;
        logic        isUnsigned;
        logic [31:0] wdata;
        logic        ovf;       // address adder overflowed
    } memReq_s;

    // Checked request with lanes already placed
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  byteEn;
        memWord_u    wdata;
        logic        isStore;
        accSize_e    size;
        logic        isUnsigned;
        logic        exc;
    } laneReq_s;

    typedef struct packed {
        logic [31:0] data;
        logic        exc;
        logic        isStore;
    } memResp_s;

    //////////////////////////////
    // AXI4-Lite channels
    //////////////////////////////

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } axiAw_s;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic [3:0]  strb;
    } axiW_s;

    typedef struct packed {
        logic        valid;
        logic [1:0]  resp;
    } axiB_s;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } axiAr_s;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic [1:0]  resp;
    } axiR_s;

endpackage

// ==== accessCheck.sv ====
`timescale 1ns/1ps
`include "memStage_config.svh"

module accessCheck (
    input  logic             clk,
    input  logic             rstN,
    input  memPkg::memReq_s  req,
    input  logic             reqValid,
    output logic             reqReady,
    output memPkg::laneReq_s lane,
    output logic             laneValid,
    input  logic             laneReady
);

    memPkg::laneReq_s laneQ;
    memPkg::laneReq_s laneNext;
    memPkg::memWord_u placed;
    logic             full;
    logic [3:0]       byteEn;
    logic             inDm;
    logic             inTc0;
    logic             inTc1;
    logic             inIrq;
    logic             isCount;
    logic             misaligned;
    logic             exc;

    //////////////////////////////
    // Byte enables and lane placement
    //////////////////////////////

    always_comb begin
        byteEn      = 4'b0000;
        placed.word = '0;
        unique case (req.size)
            memPkg::sizeWord: begin
                byteEn      = 4'b1111;
                placed.word = req.wdata;
            end
            memPkg::sizeHalf: begin
                byteEn                    = req.addr[1] ? 4'b1100 : 4'b0011;
                placed.halves[req.addr[1]] = req.wdata[15:0];
            end
            memPkg::sizeByte: begin
                byteEn                       = 4'b0001 << req.addr[1:0];
                placed.bytes[req.addr[1:0]] = req.wdata[7:0];
            end
            default: ;
        endcase
    end

    //////////////////////////////
    // Address map check
    //////////////////////////////

    assign inDm  = req.addr <= `MEM_DM_LAST;
    assign inTc0 = (req.addr >= `MEM_TC0_FIRST) && (req.addr <= `MEM_TC0_LAST);
    assign inTc1 = (req.addr >= `MEM_TC1_FIRST) && (req.addr <= `MEM_TC1_LAST);
    assign inIrq = (req.addr >= `MEM_IRQ_FIRST) && (req.addr <= `MEM_IRQ_LAST);

    // Any byte inside a count word
    assign isCount = (req.addr[31:2] == `MEM_TC0_COUNT >> 2) ||
                     (req.addr[31:2] == `MEM_TC1_COUNT >> 2);

    assign misaligned = ((req.size == memPkg::sizeWord) && (req.addr[1:0] != 2'b00)) ||
                        ((req.size == memPkg::sizeHalf) && req.addr[0]);

    assign exc = misaligned
               || ((req.size != memPkg::sizeWord) && (inTc0 || inTc1))
               || req.ovf
               || (req.isStore && isCount)
               || !(inDm || inTc0 || inTc1 || inIrq);

    always_comb begin
        laneNext.addr       = req.addr;
        laneNext.byteEn     = byteEn;
        laneNext.wdata      = placed;
        laneNext.isStore    = req.isStore;
        laneNext.size       = req.size;
        laneNext.isUnsigned = req.isUnsigned;
        laneNext.exc        = exc;
    end

    // Single entry holding register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (reqValid && reqReady) begin
            full <= 1'b1;
        end else if (laneValid && laneReady) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            laneQ <= laneNext;
        end
    end

    assign reqReady  = !full;
    assign laneValid = full;
    assign lane      = laneQ;

endmodule

// ==== axiLiteMaster.sv ====
`timescale 1ns/1ps

module axiLiteMaster (
    input  logic             clk,
    input  logic             rstN,
    input  memPkg::laneReq_s lane,
    input  logic             laneValid,
    output logic             laneReady,
    output memPkg::axiAw_s   aw,
    input  logic             awReady,
    output memPkg::axiW_s    w,
    input  logic             wReady,
    input  memPkg::axiB_s    b,
    output logic             bReady,
    output memPkg::axiAr_s   ar,
    input  logic             arReady,
    input  memPkg::axiR_s    r,
    output logic             rReady,
    output memPkg::memWord_u raw,
    output logic [1:0]       rawAddrLo,
    output memPkg::accSize_e rawSize,
    output logic             rawUnsigned,
    output logic             rawStore,
    output logic             rawExc,
    output logic             rawValid,
    input  logic             rawReady
);

    typedef enum logic [2:0] {
        stIdle,
        stWrAddr,
        stWaitB,
        stRdAddr,
        stWaitR,
        stDone
    } state_e;

    state_e           state;
    logic             awSent;
    logic             wSent;
    logic             awDone;
    logic             wDone;
    memPkg::memWord_u rawWord;

    // Each of AW and W drops once its own handshake is seen
    assign awDone = awSent || (aw.valid && awReady);
    assign wDone  = wSent || (w.valid && wReady);

    //////////////////////////////
    // Transaction FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= stIdle;
            awSent <= 1'b0;
            wSent  <= 1'b0;
        end else begin
            unique case (state)
                stIdle: begin
                    awSent <= 1'b0;
                    wSent  <= 1'b0;
                    if (laneValid) begin
                        if (lane.exc) begin
                            state <= stDone;
                        end else if (lane.isStore) begin
                            state <= stWrAddr;
                        end else begin
                            state <= stRdAddr;
                        end
                    end
                end
                stWrAddr: begin
                    awSent <= awDone;
                    wSent  <= wDone;
                    if (awDone && wDone) begin
                        state <= stWaitB;
                    end
                end
                stWaitB:  if (b.valid) state <= stDone;
                stRdAddr: if (arReady) state <= stWaitR;
                stWaitR:  if (r.valid) state <= stDone;
                stDone:   if (rawReady) state <= stIdle;
                default:  state <= stIdle;
            endcase
        end
    end

    // Read word; stores and refused accesses report zero
    always_ff @(posedge clk) begin
        if (state == stIdle && laneValid && lane.exc) begin
            rawWord.word <= '0;
        end else if (state == stWaitB && b.valid) begin
            rawWord.word <= '0;
        end else if (state == stWaitR && r.valid) begin
            rawWord.word <= r.data;
        end
    end

    //////////////////////////////
    // Bus and downstream outputs
    //////////////////////////////

    assign aw.valid = (state == stWrAddr) && !awSent;
    assign aw.addr  = lane.addr;
    assign w.valid  = (state == stWrAddr) && !wSent;
    assign w.data   = lane.wdata.word;
    assign w.strb   = lane.byteEn;
    assign bReady   = state == stWaitB;
    assign ar.valid = state == stRdAddr;
    assign ar.addr  = lane.addr;
    assign rReady   = state == stWaitR;

    // Lane register stays full until the result moves on
    assign laneReady   = (state == stDone) && rawReady;
    assign rawValid    = state == stDone;
    assign raw         = rawWord;
    assign rawAddrLo   = lane.addr[1:0];
    assign rawSize     = lane.size;
    assign rawUnsigned = lane.isUnsigned;
    assign rawStore    = lane.isStore;
    assign rawExc      = lane.exc;

endmodule

// ==== loadExtend.sv ====
`timescale 1ns/1ps

module loadExtend (
    input  logic             clk,
    input  logic             rstN,
    input  memPkg::memWord_u raw,
    input  logic [1:0]       rawAddrLo,
    input  memPkg::accSize_e rawSize,
    input  logic             rawUnsigned,
    input  logic             rawStore,
    input  logic             rawExc,
    input  logic             rawValid,
    output logic             rawReady,
    output memPkg::memResp_s resp,
    output logic             respValid,
    input  logic             respReady
);

    memPkg::memResp_s respQ;
    logic [15:0]      halfSel;
    logic [7:0]       byteSel;
    logic [31:0]      loadData;

    assign halfSel = raw.halves[rawAddrLo[1]];
    assign byteSel = raw.bytes[rawAddrLo];

    // Sign or zero extension
    always_comb begin
        unique case (rawSize)
            memPkg::sizeHalf: loadData = {{16{!rawUnsigned && halfSel[15]}}, halfSel};
            memPkg::sizeByte: loadData = {{24{!rawUnsigned && byteSel[7]}}, byteSel};
            default:          loadData = raw.word;
        endcase
        if (rawStore || rawExc) begin
            loadData = '0;
        end
    end

    // Held until the pipeline takes it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            respValid <= 1'b0;
        end else if (rawValid && rawReady) begin
            respValid <= 1'b1;
        end else if (respReady) begin
            respValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rawValid && rawReady) begin
            respQ.data    <= loadData;
            respQ.exc     <= rawExc;
            respQ.isStore <= rawStore;
        end
    end

    assign rawReady = !respValid || respReady;
    assign resp     = respQ;

endmodule

// ==== dataRam.sv ====
`timescale 1ns/1ps
`include "memStage_config.svh"

module dataRam (
    input  logic           clk,
    input  logic           rstN,
    input  memPkg::axiAw_s aw,
    output logic           awReady,
    input  memPkg::axiW_s  w,
    output logic           wReady,
    output memPkg::axiB_s  b,
    input  logic           bReady,
    input  memPkg::axiAr_s ar,
    output logic           arReady,
    output memPkg::axiR_s  r,
    input  logic           rReady
);

    localparam int ramAddrBits = $clog2(`MEM_DM_WORDS);

    logic [31:0] ramMem [`MEM_DM_WORDS];
    logic [31:0] devReg [`MEM_DEV_WORDS];
    logic        bValid;
    logic        rValid;
    logic [31:0] rData;
    logic        wrFire;
    logic        rdFire;

    // Timer 0 words 0..2, timer 1 words 3..5, interrupt word 6
    function automatic logic [2:0] devIndex(input logic [31:0] addr);
        if (addr[5]) begin
            return 3'd6;
        end else if (addr[4]) begin
            return 3'd3 + {1'b0, addr[3:2]};
        end
        return {1'b0, addr[3:2]};
    endfunction

    function automatic logic isDev(input logic [31:0] addr);
        return addr >= `MEM_TC0_FIRST;
    endfunction

    //////////////////////////////
    // Write path
    //////////////////////////////

    // AW and W are taken together, one at a time
    assign wrFire  = aw.valid && w.valid && !bValid;
    assign awReady = wrFire;
    assign wReady  = wrFire;

    always_ff @(posedge clk) begin
        if (wrFire && !isDev(aw.addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    ramMem[aw.addr[ramAddrBits+1:2]][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < `MEM_DEV_WORDS; k++) begin
                devReg[k] <= '0;
            end
        end else if (wrFire && isDev(aw.addr)) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    devReg[devIndex(aw.addr)][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // Read path and responses
    //////////////////////////////

    assign rdFire  = ar.valid && arReady;
    assign arReady = !rValid;

    always_ff @(posedge clk) begin
        if (rdFire) begin
            rData <= isDev(ar.addr) ? devReg[devIndex(ar.addr)]
                                    : ramMem[ar.addr[ramAddrBits+1:2]];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bValid <= 1'b0;
            rValid <= 1'b0;
        end else begin
            if (wrFire) begin
                bValid <= 1'b1;
            end else if (bReady) begin
                bValid <= 1'b0;
            end
            if (rdFire) begin
                rValid <= 1'b1;
            end else if (rReady) begin
                rValid <= 1'b0;
            end
        end
    end

    // Always OKAY
    assign b.valid = bValid;
    assign b.resp  = 2'b00;
    assign r.valid = rValid;
    assign r.data  = rData;
    assign r.resp  = 2'b00;

endmodule

// ==== memStageTop.sv ====
`timescale 1ns/1ps

module memStageTop (
    input  logic             clk,
    input  logic             rstN,
    input  memPkg::memReq_s  req,
    input  logic             reqValid,
    output logic             reqReady,
    output memPkg::memResp_s resp,
    output logic             respValid,
    input  logic             respReady
);

    memPkg::laneReq_s lane;
    logic             laneValid;
    logic             laneReady;

    memPkg::axiAw_s   aw;
    memPkg::axiW_s    w;
    memPkg::axiB_s    b;
    memPkg::axiAr_s   ar;
    memPkg::axiR_s    r;
    logic             awReady;
    logic             wReady;
    logic             bReady;
    logic             arReady;
    logic             rReady;

    memPkg::memWord_u raw;
    logic [1:0]       rawAddrLo;
    memPkg::accSize_e rawSize;
    logic             rawUnsigned;
    logic             rawStore;
    logic             rawExc;
    logic             rawValid;
    logic             rawReady;

    accessCheck check0 (
        .clk, .rstN, .req, .reqValid, .reqReady, .lane, .laneValid, .laneReady
    );

    axiLiteMaster master0 (
        .clk, .rstN, .lane, .laneValid, .laneReady,
        .aw, .awReady, .w, .wReady, .b, .bReady, .ar, .arReady, .r, .rReady,
        .raw, .rawAddrLo, .rawSize, .rawUnsigned, .rawStore, .rawExc,
        .rawValid, .rawReady
    );

    loadExtend extend0 (
        .clk, .rstN, .raw, .rawAddrLo, .rawSize, .rawUnsigned, .rawStore, .rawExc,
        .rawValid, .rawReady, .resp, .respValid, .respReady
    );

    dataRam ram0 (
        .clk, .rstN, .aw, .awReady, .w, .wReady, .b, .bReady,
        .ar, .arReady, .r, .rReady
    );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held low for three rising edges
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

// ==== memStageTb.sv ====
`timescale 1ns/1ps
`include "memStage_config.svh"

module memStageTb;

    localparam int nWords         = 16;
    localparam int nRandom        = 24;
    localparam int totalReqs      = 2 * nWords + 18 + 13 + 19 + 12 + nWords + nRandom;
    localparam int watchdogCycles = totalReqs * 20 + 10;

    logic             clk;
    logic             rstN;
    memPkg::memReq_s  req;
    logic             reqValid;
    logic             reqReady;
    memPkg::memResp_s resp;
    logic             respValid;
    logic             respReady;
    logic             randomReady;

    integer seed;
    integer readySeed;
    int     errorCount;
    int     checkCount;
    int     sentCount;
    int     errorStart;
    int     checkStart;

    // Expected responses in request order
    memPkg::memResp_s expQ[$];
    // Byte-addressed model of data RAM and device registers
    logic [7:0]       model [int unsigned];

    tbClock clock0 (.clk, .rstN);

    memStageTop dut0 (
        .clk, .rstN, .req, .reqValid, .reqReady, .resp, .respValid, .respReady
    );

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic memPkg::memResp_s expectResp(input memPkg::memReq_s rq);
        memPkg::memResp_s res;
        int               nBytes;
        logic             inTimer;
        logic             mapped;
        logic             refused;
        logic [31:0]      val;
        nBytes  = (rq.size == memPkg::sizeWord) ? 4 : (rq.size == memPkg::sizeHalf) ? 2 : 1;
        inTimer = (rq.addr >= `MEM_TC0_FIRST && rq.addr <= `MEM_TC0_LAST) ||
                  (rq.addr >= `MEM_TC1_FIRST && rq.addr <= `MEM_TC1_LAST);
        mapped  = (rq.addr <= `MEM_DM_LAST) || inTimer ||
                  (rq.addr >= `MEM_IRQ_FIRST && rq.addr <= `MEM_IRQ_LAST);
        // Natural alignment for the access size
        refused = (rq.addr & (nBytes - 1)) != 0;
        refused = refused || (nBytes < 4 && inTimer);
        refused = refused || rq.ovf;
        refused = refused || (rq.isStore && ((rq.addr & ~32'h3) == `MEM_TC0_COUNT ||
                                             (rq.addr & ~32'h3) == `MEM_TC1_COUNT));
        refused = refused || !mapped;
        val = '0;
        if (!refused) begin
            // Lowest address goes in the low byte
            for (int i = 0; i < nBytes; i++) begin
                if (rq.isStore) begin
                    model[rq.addr + i] = rq.wdata[8*i +: 8];
                end else begin
                    val[8*i +: 8] = model[rq.addr + i];
                end
            end
            if (!rq.isStore && !rq.isUnsigned && nBytes < 4 && val[8*nBytes-1]) begin
                for (int i = nBytes; i < 4; i++) begin
                    val[8*i +: 8] = 8'hff;
                end
            end
        end
        res.data    = rq.isStore ? 32'h0 : val;
        res.exc     = refused;
        res.isStore = rq.isStore;
        return res;
    endfunction

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic sendReq(input logic [31:0] addr, input memPkg::accSize_e size,
                           input logic isStore, input logic isUnsigned,
                           input logic [31:0] wdata, input logic ovf);
        memPkg::memReq_s rq;
        rq.addr       = addr;
        rq.size       = size;
        rq.isStore    = isStore;
        rq.isUnsigned = isUnsigned;
        rq.wdata      = wdata;
        rq.ovf        = ovf;
        req       = rq;
        reqValid  = 1'b1;
        expQ.push_back(expectResp(rq));
        sentCount++;
        do @(posedge clk); while (!reqReady);
        #1;
        reqValid = 1'b0;
    endtask

    task automatic waitIdle();
        while (expQ.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic startTest();
        checkStart = checkCount;
        errorStart = errorCount;
    endtask

    task automatic reportTest(input int num, input string name);
        waitIdle();
        $display("Test %0d %s: %0d responses checked, %0d errors", num, name,
                 checkCount - checkStart, errorCount - errorStart);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic wordTest();
        logic [31:0] addrs [nWords];
        startTest();
        for (int i = 0; i < nWords; i++) begin
            addrs[i] = $random(seed) & 32'h0000_2ffc;
            sendReq(addrs[i], memPkg::sizeWord, 1'b1, 1'b0, $random(seed), 1'b0);
        end
        for (int i = 0; i < nWords; i++) begin
            sendReq(addrs[i], memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        end
        reportTest(1, "word store/load");
    endtask

    task automatic laneTest();
        logic [31:0] base;
        startTest();
        for (int i = 0; i < 4; i++) begin
            base = 32'h100 + 4 * i;
            sendReq(base, memPkg::sizeWord, 1'b1, 1'b0, $random(seed), 1'b0);
            sendReq(base + i, memPkg::sizeByte, 1'b1, 1'b0, $random(seed), 1'b0);
            sendReq(base, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        end
        for (int i = 0; i < 2; i++) begin
            base = 32'h110 + 4 * i;
            sendReq(base, memPkg::sizeWord, 1'b1, 1'b0, $random(seed), 1'b0);
            sendReq(base + 2 * i, memPkg::sizeHalf, 1'b1, 1'b0, $random(seed), 1'b0);
            sendReq(base, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        end
        reportTest(2, "sub-word stores");
    endtask

    task automatic extendTest();
        startTest();
        // Top bit set in bytes 0, 1, 3 and in both halves
        sendReq(32'h180, memPkg::sizeWord, 1'b1, 1'b0, 32'h8c7f_f09a, 1'b0);
        for (int i = 0; i < 4; i++) begin
            sendReq(32'h180 + i, memPkg::sizeByte, 1'b0, 1'b0, 32'h0, 1'b0);
            sendReq(32'h180 + i, memPkg::sizeByte, 1'b0, 1'b1, 32'h0, 1'b0);
        end
        for (int i = 0; i < 2; i++) begin
            sendReq(32'h180 + 2 * i, memPkg::sizeHalf, 1'b0, 1'b0, 32'h0, 1'b0);
            sendReq(32'h180 + 2 * i, memPkg::sizeHalf, 1'b0, 1'b1, 32'h0, 1'b0);
        end
        reportTest(3, "load extension");
    endtask

    task automatic excTest();
        startTest();
        sendReq(32'h0000_0102, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        sendReq(32'h0000_0101, memPkg::sizeWord, 1'b1, 1'b0, 32'h1111_1111, 1'b0);
        sendReq(32'h0000_0103, memPkg::sizeHalf, 1'b0, 1'b0, 32'h0, 1'b0);
        sendReq(32'h0000_0105, memPkg::sizeHalf, 1'b1, 1'b0, 32'h2222_2222, 1'b0);
        sendReq(32'h0000_7f00, memPkg::sizeHalf, 1'b0, 1'b0, 32'h0, 1'b0);
        sendReq(32'h0000_7f14, memPkg::sizeByte, 1'b1, 1'b0, 32'h3333_3333, 1'b0);
        sendReq(32'h0000_7f09, memPkg::sizeByte, 1'b0, 1'b1, 32'h0, 1'b0);
        sendReq(32'h0000_0100, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b1);
        sendReq(32'h0000_0104, memPkg::sizeWord, 1'b1, 1'b0, 32'h4444_4444, 1'b1);
        sendReq(32'h0000_7f08, memPkg::sizeWord, 1'b1, 1'b0, 32'hdead_beef, 1'b0);
        sendReq(32'h0000_7f18, memPkg::sizeWord, 1'b1, 1'b0, 32'hcafe_f00d, 1'b0);
        sendReq(32'h0000_3000, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        sendReq(32'h0000_4000, memPkg::sizeWord, 1'b1, 1'b0, 32'h5555_5555, 1'b0);
        sendReq(32'h0000_7f0c, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        sendReq(32'h0000_7f24, memPkg::sizeByte, 1'b1, 1'b0, 32'h6666_6666, 1'b0);
        // Nothing above may have changed memory
        sendReq(32'h0000_0100, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        sendReq(32'h0000_0104, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        sendReq(32'h0000_7f08, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        sendReq(32'h0000_7f18, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        reportTest(4, "exceptions");
    endtask

    task automatic deviceTest();
        startTest();
        // Count words (index 2) are skipped for stores
        for (int i = 0; i < 2; i++) begin
            sendReq(`MEM_TC0_FIRST + 4 * i, memPkg::sizeWord, 1'b1, 1'b0, $random(seed), 1'b0);
            sendReq(`MEM_TC1_FIRST + 4 * i, memPkg::sizeWord, 1'b1, 1'b0, $random(seed), 1'b0);
        end
        sendReq(`MEM_IRQ_FIRST, memPkg::sizeWord, 1'b1, 1'b0, $random(seed), 1'b0);
        for (int i = 0; i < 3; i++) begin
            sendReq(`MEM_TC0_FIRST + 4 * i, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
            sendReq(`MEM_TC1_FIRST + 4 * i, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        end
        sendReq(`MEM_IRQ_FIRST, memPkg::sizeWord, 1'b0, 1'b0, 32'h0, 1'b0);
        reportTest(5, "device registers");
    endtask

    task automatic backPressureTest();
        logic [31:0]      pick;
        logic [31:0]      off;
        logic [31:0]      addr;
        memPkg::accSize_e size;
        startTest();
        for (int i = 0; i < nWords; i++) begin
            sendReq(32'h200 + 4 * i, memPkg::sizeWord, 1'b1, 1'b0, $random(seed), 1'b0);
        end
        randomReady = 1'b1;
        for (int i = 0; i < nRandom; i++) begin
            pick = $random(seed);
            off  = $random(seed);
            size = memPkg::accSize_e'(pick[7:0] % 3);
            addr = 32'h200 + (off & 32'h3c);
            if (size == memPkg::sizeHalf) begin
                addr = addr + (off & 32'h2);
            end else if (size == memPkg::sizeByte) begin
                addr = addr + (off & 32'h3);
            end
            sendReq(addr, size, pick[8], pick[9], $random(seed), 1'b0);
        end
        waitIdle();
        randomReady = 1'b0;
        reportTest(6, "response back-pressure");
    endtask

    //////////////////////////////
    // Response ready and checking
    //////////////////////////////

    always @(posedge clk) begin : driveReady
        logic useRandom;
        useRandom = randomReady;
        #1;
        if (useRandom) begin
            respReady = ($random(readySeed) & 1) != 0;
        end else begin
            respReady = 1'b1;
        end
    end

    always @(posedge clk) begin : compareResp
        memPkg::memResp_s expected;
        if (respValid && respReady) begin
            assert (expQ.size() != 0) else begin
                $display("Response at %0t arrived with no request outstanding", $time);
                errorCount++;
            end
            if (expQ.size() != 0) begin
                expected = expQ.pop_front();
                checkCount++;
                assert (resp === expected) else begin
                    $display("FAIL %0t: got data %h exc %b store %b, expected %h %b %b",
                             $time, resp.data, resp.exc, resp.isStore,
                             expected.data, expected.exc, expected.isStore);
                    errorCount++;
                end
            end
        end
    end

    // Ends a run that stalls
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout after %0d cycles: %0d of %0d responses never arrived",
                 watchdogCycles, expQ.size(), sentCount);
        $display("sim failed");
        $finish;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        seed        = 32'h0809154e;
        readySeed   = 32'h0809154e;
        req         = '0;
        reqValid    = 1'b0;
        respReady   = 1'b1;
        randomReady = 1'b0;
        errorCount  = 0;
        checkCount  = 0;
        sentCount   = 0;
        // Device registers come out of reset as zero
        for (int a = `MEM_TC0_FIRST; a <= `MEM_IRQ_LAST; a++) begin
            model[a] = 8'h00;
        end
        @(posedge rstN);
        @(posedge clk);
        #1;
        assert (reqReady === 1'b1 && respValid === 1'b0) else begin
            $display("FAIL %0t: reqReady %b respValid %b after reset", $time,
                     reqReady, respValid);
            errorCount++;
        end
        wordTest();
        laneTest();
        extendTest();
        excTest();
        deviceTest();
        backPressureTest();
        $display("Requests %0d, responses checked %0d, errors %0d",
                 sentCount, checkCount, errorCount);
        if (errorCount == 0 && checkCount == sentCount) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
memPkg.sv
accessCheck.sv
axiLiteMaster.sv
loadExtend.sv
dataRam.sv
memStageTop.sv
tbClock.sv
memStageTb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - include_dirs:
      - .
    files:
      - memPkg.sv
      - accessCheck.sv
      - axiLiteMaster.sv
      - loadExtend.sv
      - dataRam.sv
      - memStageTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbClock.sv
      - memStageTb.sv
